// ==== filelist.f ====
+incdir+include
rtl/nes_bus_pkg.sv
rtl/bus_master_if.sv
rtl/cpu_clock_divider.sv
rtl/sprite_dmc_dma.sv
rtl/cpu_bus_decoder.sv
rtl/nes_cpu_bus.sv
verif/tb_nes_cpu_bus.sv

// ==== verif/tb_nes_cpu_bus.sv ====
`timescale 1ns/10ps

`include "nes_bus_consts.svh"

// Testbench for the NES CPU bus core
// A clock-level model predicts every output while the stimulus walks the CPU through bus cycles
module tb_nes_cpu_bus;

	localparam int RESET_CLOCKS   = 4;
	localparam int ENABLE_CYCLES  = 8;   // Idle reads while the enables free-run
	localparam int N_READS        = 200;
	localparam int N_JOY          = 40;  // Write then read over two CPU cycles
	localparam int N_DMC          = 12;  // At most five CPU cycles each
	localparam int SPRITE_CYCLES  = 700; // 512 transfer cycles plus alignment and DMC steals
	localparam int TOTAL_CLOCKS   = RESET_CLOCKS
		+ 12 * (ENABLE_CYCLES + N_READS + 2 * N_JOY + 5 * N_DMC + 2 * SPRITE_CYCLES);
	localparam int TIMEOUT_CLOCKS = 2 * TOTAL_CLOCKS;

	localparam int SPR_IDLE = 0;
	localparam int SPR_WAIT = 1; // CPU paused and not yet aligned
	localparam int SPR_XFER = 2;

	logic clk, reset, i_cpu_read, i_dmc_req, i_prg_valid;
	logic [15:0] i_cpu_addr, i_dmc_addr;
	logic [7:0] i_cpu_dout, i_ppu_dout, i_apu_status, i_prg_dout;
	logic [4:0] i_joy1_data, i_joy2_data;
	logic o_cpu_ce, o_ppu_ce, o_odd_cycle, o_dmc_ack, o_pause_cpu;
	logic o_bus_read_stb, o_bus_write_stb, o_ppu_cs, o_apu_cs, o_sprite_trigger;
	logic [15:0] o_bus_addr;
	logic [7:0] o_bus_dout, o_cpu_din;
	logic [2:0] o_joypad_out;
	logic [1:0] o_joypad_clock;

	logic [7:0]  prg_mem [0:65535]; // Cartridge image
	logic [31:0] rng_state;
	int          fill_addr;
	string       test_name;
	logic        last_ack;          // Sampled at the last CPU tick
	logic        last_pause;
	int          sprite_pairs;      // Writes to 2004 seen on the DUT bus
	int          error_count;
	int          cycle_count;

	// Reference model state
	logic                   model_valid;
	int                     clk_since_reset;
	logic                   model_odd;
	logic                   model_dmc;  // DMC fetch armed
	logic                   next_dmc;
	int                     model_spr;
	int                     next_spr;
	nes_bus_pkg::bus_addr_u model_src;  // Sprite page:offset
	nes_bus_pkg::byte_t     model_byte; // Byte for the next 2004 write
	nes_bus_pkg::byte_t     model_open; // Open bus value
	logic [2:0]             model_joy;

	// Expected values in the current clock
	logic                   e_ce, e_dmc, e_enable, e_read, e_trig;
	nes_bus_pkg::bus_addr_u e_addr;
	nes_bus_pkg::byte_t     e_dout, e_din;

	nes_cpu_bus dut (.*);

	// Cartridge answers outside the PPU and APU windows
	assign i_prg_dout  = prg_mem[o_bus_addr];
	assign i_prg_valid = (o_bus_addr < `PPU_BASE) || (o_bus_addr >= `APU_END);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("tests failed");
		error_count = error_count + 1;
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_byte(input string name, input nes_bus_pkg::byte_t exp,
		input nes_bus_pkg::byte_t act);
		if (act !== exp) begin
			fail_now($sformatf("mismatch %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_addr(input string name, input nes_bus_pkg::bus_addr_u exp,
		input nes_bus_pkg::bus_addr_u act);
		if (act.word !== exp.word) begin
			fail_now($sformatf("mismatch %s expected %h actual %h", name, exp.word, act.word));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_now($sformatf("mismatch %s expected %b actual %b", name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			fail_now($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
		end
	endtask

	// Read data priority from the joypads down to the cartridge
	function automatic nes_bus_pkg::byte_t expected_din(input logic [15:0] a,
		input nes_bus_pkg::byte_t open);
		if (a == `JOY1_ADDR) return {open[7:5], i_joy1_data};
		if (a == `JOY2_ADDR) return {open[7:5], i_joy2_data};
		if (a == `APU_STATUS_ADDR) return i_apu_status;
		if (a >= `APU_BASE && a < `APU_END) return open;
		if (a >= `PPU_BASE && a < `PPU_END) return i_ppu_dout;
		return prg_mem[a]; // Cartridge always valid out here
	endfunction

	// Predict and compare halfway through each clock
	always @(negedge clk) begin
		if (model_valid) begin
			e_ce     = (clk_since_reset % 12 == 11);
			e_dmc    = model_dmc && !model_odd; // DMC owns the even cycle
			e_enable = e_dmc || (model_spr == SPR_XFER);
			if (e_dmc) e_addr.word = i_dmc_addr;
			else if (e_enable && !model_odd) e_addr = model_src;
			else if (e_enable) e_addr.word = `OAM_DATA_ADDR;
			else e_addr.word = i_cpu_addr;
			e_read = e_enable ? !model_odd : i_cpu_read;
			e_dout = e_enable ? model_byte : i_cpu_dout;
			e_din  = reset ? 8'h00 : expected_din(e_addr.word, model_open);
			e_trig = e_ce && !e_read && (e_addr.word == `OAM_DMA_ADDR);

			check_bit({test_name, " o_cpu_ce"}, e_ce, o_cpu_ce);
			check_bit({test_name, " o_ppu_ce"}, clk_since_reset % 4 == 3, o_ppu_ce);
			check_bit({test_name, " o_odd_cycle"}, model_odd, o_odd_cycle);
			check_bit({test_name, " o_pause_cpu"}, (model_spr != SPR_IDLE) || i_dmc_req,
				o_pause_cpu);
			check_bit({test_name, " o_dmc_ack"}, e_dmc, o_dmc_ack);
			check_addr({test_name, " o_bus_addr"}, e_addr, o_bus_addr);
			check_bit({test_name, " o_bus_read_stb"}, e_ce && e_read, o_bus_read_stb);
			check_bit({test_name, " o_bus_write_stb"}, e_ce && !e_read, o_bus_write_stb);
			if (!e_read) check_byte({test_name, " o_bus_dout"}, e_dout, o_bus_dout);
			check_byte({test_name, " o_cpu_din"}, e_din, o_cpu_din);
			check_bit({test_name, " o_ppu_cs"},
				(e_addr.word >= `PPU_BASE) && (e_addr.word < `PPU_END), o_ppu_cs);
			check_bit({test_name, " o_apu_cs"},
				(e_addr.word >= `APU_BASE) && (e_addr.word < `APU_END), o_apu_cs);
			check_bit({test_name, " o_sprite_trigger"}, e_trig, o_sprite_trigger);
			check_byte({test_name, " o_joypad_out"}, {5'd0, model_joy}, {5'd0, o_joypad_out});
			check_bit({test_name, " o_joypad_clock[0]"},
				e_ce && e_read && (e_addr.word == `JOY1_ADDR), o_joypad_clock[0]);
			check_bit({test_name, " o_joypad_clock[1]"},
				e_ce && e_read && (e_addr.word == `JOY2_ADDR), o_joypad_clock[1]);

			if (o_bus_write_stb && (o_bus_addr == `OAM_DATA_ADDR)) begin
				sprite_pairs = sprite_pairs + 1; // One OAM write closes each pair
			end
		end
	end

	// Model state moves on the rising edge while inputs still hold their last values
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CLOCKS) begin
			fail_now("timeout, the DUT never finished the test sequence");
		end
		if (reset) begin
			clk_since_reset = 0;
			model_odd  = 1'b1;
			model_dmc  = 1'b0;
			model_spr  = SPR_IDLE;
			model_joy  = 3'b000;
			model_open = 8'h00;
		end else begin
			model_open = e_din; // Bus keeps the last value
			if (e_ce && !e_read && e_addr.word == `JOY1_ADDR) model_joy = e_dout[2:0];
			if (e_ce) begin
				next_dmc = model_dmc;
				if (!model_dmc && i_dmc_req && i_cpu_read && !model_odd) next_dmc = 1'b1;
				else if (model_dmc && !model_odd) next_dmc = 1'b0;
				next_spr = model_spr;
				if (model_spr == SPR_XFER && model_odd && model_src.paged.offset == 8'hff)
					next_spr = SPR_IDLE;
				else if (model_spr == SPR_XFER && !model_odd && model_dmc)
					next_spr = SPR_WAIT; // Stolen read so the pair starts over
				else if (model_spr == SPR_WAIT && i_cpu_read && model_odd)
					next_spr = SPR_XFER;
				else if (e_trig)
					next_spr = SPR_WAIT;
				if (e_trig) begin
					model_src.paged.page   = i_cpu_dout;
					model_src.paged.offset = 8'h00;
				end else if (model_spr == SPR_XFER && model_odd) begin
					model_src.paged.offset = model_src.paged.offset + 8'd1;
				end
				if (model_spr == SPR_XFER) model_byte = e_din;
				model_dmc = next_dmc;
				model_spr = next_spr;
				model_odd = !model_odd;
			end
			clk_since_reset = clk_since_reset + 1;
		end
		model_valid = 1'b1;
	end

	// One CPU cycle ending just after the tick that closes it
	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data, input logic read);
		logic [31:0] rnd;
		logic        seen;
		rnd          = lcg_next();
		i_cpu_addr   = addr;
		i_cpu_dout   = data;
		i_cpu_read   = read;
		i_ppu_dout   = rnd[31:24];
		i_apu_status = rnd[23:16];
		i_joy1_data  = rnd[14:10];
		i_joy2_data  = rnd[9:5];
		seen = 1'b0;
		while (!seen) begin
			@(negedge clk);
			seen       = o_cpu_ce;
			last_ack   = o_dmc_ack;
			last_pause = o_pause_cpu;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic random_reads();
		logic [31:0] rnd;
		logic [15:0] addr;
		test_name = "read path";
		repeat (N_READS) begin
			rnd = lcg_next();
			case (rnd[23:16] % 8'd6)
				0: addr = `APU_STATUS_ADDR;
				1: addr = `JOY1_ADDR;
				2: addr = `JOY2_ADDR;
				3: addr = `APU_BASE + {11'd0, rnd[4:0] % 5'd20}; // 4000 to 4013
				4: addr = `PPU_BASE + {3'd0, rnd[12:0]};
				default: addr = {rnd[15], 2'b00, rnd[12:0]};    // RAM or PRG ROM
			endcase
			bus_cycle(addr, rnd[7:0], 1'b1);
		end
	endtask

	task automatic joypad_test();
		logic [31:0] rnd;
		test_name = "joypads";
		repeat (N_JOY) begin
			rnd = lcg_next();
			bus_cycle(`JOY1_ADDR, rnd[7:0], 1'b0);
			check_byte("joypads strobe latch", {5'd0, rnd[2:0]}, {5'd0, o_joypad_out});
			bus_cycle(rnd[8] ? `JOY2_ADDR : `JOY1_ADDR, 8'h00, 1'b1);
		end
	endtask

	task automatic sprite_transfer(input logic with_dmc);
		logic [31:0] rnd;
		logic [7:0]  page;
		rnd  = lcg_next();
		page = rnd[31:24];
		if (page >= 8'h20 && page <= 8'h40) page[7] = 1'b1; // Keep the source in PRG space
		sprite_pairs = 0;
		bus_cycle(`OAM_DMA_ADDR, page, 1'b0);
		check_bit({test_name, " pause after trigger"}, 1'b1, o_pause_cpu);
		last_pause = 1'b1;
		while (last_pause) begin
			rnd = lcg_next();
			if (with_dmc && !i_dmc_req && rnd[31:28] == 4'h0) begin
				i_dmc_req  = 1'b1;
				i_dmc_addr = {1'b1, rnd[14:0]};
			end
			bus_cycle({1'b1, rnd[26:12]}, 8'h00, 1'b1); // Paused CPU keeps reading
			if (last_ack) i_dmc_req = 1'b0;
		end
		check_count({test_name, " read/write pairs"}, 256, sprite_pairs);
	endtask

	task automatic dmc_fetch_once();
		logic [31:0] rnd;
		rnd        = lcg_next();
		i_dmc_addr = {1'b1, rnd[30:16]};
		i_dmc_req  = 1'b1;
		last_ack   = 1'b0;
		while (!last_ack) begin
			bus_cycle({1'b1, rnd[14:0]}, 8'h00, 1'b1);
		end
		i_dmc_req = 1'b0; // APU drops the request once acked
		bus_cycle({1'b1, rnd[14:0]}, 8'h00, 1'b1);
	endtask

	initial begin
		rng_state    = 32'h58c36f9f;
		error_count  = 0;
		cycle_count  = 0;
		sprite_pairs = 0;
		model_valid  = 1'b0;
		test_name    = "reset";
		reset        = 1'b1;
		i_cpu_addr   = 16'h0000;
		i_cpu_dout   = 8'h00;
		i_cpu_read   = 1'b1;
		i_dmc_req    = 1'b0;
		i_dmc_addr   = 16'hc000;
		i_ppu_dout   = 8'h00;
		i_apu_status = 8'h00;
		i_joy1_data  = 5'd0;
		i_joy2_data  = 5'd0;
		for (fill_addr = 0; fill_addr < 65536; fill_addr = fill_addr + 1) begin
			prg_mem[fill_addr] = fill_addr[7:0] ^ (fill_addr[15:8] * 8'd29) ^ 8'h96;
		end
		repeat (RESET_CLOCKS) @(posedge clk);
		#1;
		reset = 1'b0;

		test_name = "enables";
		repeat (ENABLE_CYCLES) bus_cycle(16'h8000, 8'h00, 1'b1);
		random_reads();
		joypad_test();
		test_name = "sprite dma";
		sprite_transfer(1'b0);
		test_name = "dmc dma";
		repeat (N_DMC) dmc_fetch_once();
		test_name = "sprite dma with dmc";
		sprite_transfer(1'b1);

		if (error_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("tests failed");
			$fatal(1, "errors were found");
		end
	end

endmodule

// ==== rtl/nes_cpu_bus.sv ====
`timescale 1ns/10ps

// CPU side bus core
// Divider feeds the DMA, the DMA feeds the bus decoder
module nes_cpu_bus (
	input  logic        clk,
	input  logic        reset,
	// CPU bus
	input  logic [15:0] i_cpu_addr,
	input  logic [7:0]  i_cpu_dout,
	input  logic        i_cpu_read,       // 1 read, 0 write
	// APU DMC request
	input  logic        i_dmc_req,
	input  logic [15:0] i_dmc_addr,
	// Devices
	input  logic [7:0]  i_ppu_dout,
	input  logic [7:0]  i_apu_status,
	input  logic [7:0]  i_prg_dout,
	input  logic        i_prg_valid,
	input  logic [4:0]  i_joy1_data,
	input  logic [4:0]  i_joy2_data,
	// Timing
	output logic        o_cpu_ce,
	output logic        o_ppu_ce,
	output logic        o_odd_cycle,
	// DMA
	output logic        o_dmc_ack,
	output logic        o_pause_cpu,      // Holds the CPU
	// Shared bus
	output logic [15:0] o_bus_addr,
	output logic [7:0]  o_bus_dout,
	output logic [7:0]  o_cpu_din,        // Read data to CPU and DMA
	output logic        o_bus_read_stb,
	output logic        o_bus_write_stb,
	output logic        o_ppu_cs,
	output logic        o_apu_cs,
	output logic        o_sprite_trigger,
	output logic [2:0]  o_joypad_out,
	output logic [1:0]  o_joypad_clock
);

	bus_master_if dma_bus ();

	cpu_clock_divider u_divider (
		.clk         (clk),
		.reset       (reset),
		.o_cpu_ce    (o_cpu_ce),
		.o_ppu_ce    (o_ppu_ce),
		.o_odd_cycle (o_odd_cycle)
	);

	sprite_dmc_dma u_dma (
		.clk              (clk),
		.reset            (reset),
		.i_cpu_ce         (o_cpu_ce),
		.i_odd_cycle      (o_odd_cycle),
		.i_sprite_trigger (o_sprite_trigger), // Decoded from the bus
		.i_dmc_req        (i_dmc_req),
		.i_cpu_read       (i_cpu_read),
		.i_cpu_dout       (i_cpu_dout),
		.i_bus_din        (o_cpu_din),        // Same data the CPU sees
		.i_dmc_addr       (i_dmc_addr),
		.o_dmc_ack        (o_dmc_ack),
		.o_pause_cpu      (o_pause_cpu),
		.bus              (dma_bus)
	);

	cpu_bus_decoder u_decoder (
		.clk              (clk),
		.reset            (reset),
		.i_cpu_ce         (o_cpu_ce),
		.i_cpu_read       (i_cpu_read),
		.i_cpu_addr       (i_cpu_addr),
		.i_cpu_dout       (i_cpu_dout),
		.i_ppu_dout       (i_ppu_dout),
		.i_apu_status     (i_apu_status),
		.i_prg_dout       (i_prg_dout),
		.i_prg_valid      (i_prg_valid),
		.i_joy1_data      (i_joy1_data),
		.i_joy2_data      (i_joy2_data),
		.bus              (dma_bus),
		.o_bus_addr       (o_bus_addr),
		.o_bus_dout       (o_bus_dout),
		.o_cpu_din        (o_cpu_din),
		.o_bus_read_stb   (o_bus_read_stb),
		.o_bus_write_stb  (o_bus_write_stb),
		.o_ppu_cs         (o_ppu_cs),
		.o_apu_cs         (o_apu_cs),
		.o_sprite_trigger (o_sprite_trigger),
		.o_joypad_out     (o_joypad_out),
		.o_joypad_clock   (o_joypad_clock)
	);

endmodule

// ==== rtl/cpu_bus_decoder.sv ====
`timescale 1ns/10ps

`include "nes_bus_consts.svh"

// Bus master mux, device decode and CPU read data
module cpu_bus_decoder (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_cpu_ce,
	input  logic                   i_cpu_read,     // CPU read/write level
	input  nes_bus_pkg::bus_addr_u i_cpu_addr,
	input  nes_bus_pkg::byte_t     i_cpu_dout,
	input  nes_bus_pkg::byte_t     i_ppu_dout,     // PPU register read data
	input  nes_bus_pkg::byte_t     i_apu_status,   // 4015 read data
	input  nes_bus_pkg::byte_t     i_prg_dout,     // Cartridge read data
	input  logic                   i_prg_valid,    // Cartridge drives the bus
	input  logic [4:0]             i_joy1_data,
	input  logic [4:0]             i_joy2_data,
	bus_master_if.decoder          bus,
	output nes_bus_pkg::bus_addr_u o_bus_addr,
	output nes_bus_pkg::byte_t     o_bus_dout,
	output nes_bus_pkg::byte_t     o_cpu_din,
	output logic                   o_bus_read_stb,
	output logic                   o_bus_write_stb,
	output logic                   o_ppu_cs,
	output logic                   o_apu_cs,
	output logic                   o_sprite_trigger, // Write strobe to 4014
	output logic [2:0]             o_joypad_out,     // Strobe latch, bit 0 reloads pads
	output logic [1:0]             o_joypad_clock    // One per pad
);

	logic               bus_read;   // Read level after the master mux
	logic               joy1_cs;
	logic               joy2_cs;
	logic               status_cs;
	logic               oam_dma_cs;
	nes_bus_pkg::byte_t open_bus;   // Last value on the data bus

	// Master select, DMA wins when it asks
	assign o_bus_addr = bus.enable ? bus.addr : i_cpu_addr;
	assign o_bus_dout = bus.enable ? bus.wdata : i_cpu_dout;
	assign bus_read   = bus.enable ? bus.read : i_cpu_read;

	// Strobes last one clock per CPU cycle
	assign o_bus_read_stb  = bus_read && i_cpu_ce;
	assign o_bus_write_stb = !bus_read && i_cpu_ce;

	// Device windows
	assign o_ppu_cs = (o_bus_addr.word >= `PPU_BASE) && (o_bus_addr.word < `PPU_END);
	assign o_apu_cs = (o_bus_addr.word >= `APU_BASE) && (o_bus_addr.word < `APU_END);

	// Single registers
	assign joy1_cs    = (o_bus_addr.word == `JOY1_ADDR);
	assign joy2_cs    = (o_bus_addr.word == `JOY2_ADDR);
	assign status_cs  = (o_bus_addr.word == `APU_STATUS_ADDR);
	assign oam_dma_cs = (o_bus_addr.word == `OAM_DMA_ADDR);

	assign o_sprite_trigger = oam_dma_cs && o_bus_write_stb;

	// Pads are clocked by reading their port
	assign o_joypad_clock = {joy2_cs && o_bus_read_stb, joy1_cs && o_bus_read_stb};

	// Read data priority
	always_comb begin
		if (reset) begin
			o_cpu_din = 8'h00;
		end else if (joy1_cs) begin
			o_cpu_din = {open_bus[7:5], i_joy1_data}; // Top bits float
		end else if (joy2_cs) begin
			o_cpu_din = {open_bus[7:5], i_joy2_data};
		end else if (status_cs) begin
			o_cpu_din = i_apu_status;
		end else if (o_apu_cs) begin
			o_cpu_din = open_bus; // Write-only APU registers
		end else if (o_ppu_cs) begin
			o_cpu_din = i_ppu_dout;
		end else if (i_prg_valid) begin
			o_cpu_din = i_prg_dout;
		end else begin
			o_cpu_din = open_bus; // Nothing drives the bus
		end
	end

	// Bus capacitance holds the previous value
	always_ff @(posedge clk) begin
		open_bus <= o_cpu_din;
	end

	// Joypad strobe latch
	always_ff @(posedge clk) begin
		if (reset) begin
			o_joypad_out <= 3'b000;
		end else if (joy1_cs && o_bus_write_stb) begin
			o_joypad_out <= o_bus_dout[2:0];
		end
	end

endmodule

// ==== rtl/sprite_dmc_dma.sv ====
`timescale 1ns/10ps

`include "nes_bus_consts.svh"

// Sprite OAM DMA and DMC sample DMA
// Sprite DMA reads on even cycles and writes 2004 on odd cycles
// DMC fetch takes an even cycle and leaves the next odd cycle idle
module sprite_dmc_dma (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_cpu_ce,         // CPU cycle tick
	input  logic                   i_odd_cycle,      // Current APU half cycle
	input  logic                   i_sprite_trigger, // Write strobe to 4014
	input  logic                   i_dmc_req,        // Held by the APU until acked
	input  logic                   i_cpu_read,       // CPU in a read cycle
	input  nes_bus_pkg::byte_t     i_cpu_dout,       // Page number written to 4014
	input  nes_bus_pkg::byte_t     i_bus_din,        // Read data back from the bus
	input  nes_bus_pkg::bus_addr_u i_dmc_addr,       // Next DMC sample address
	output logic                   o_dmc_ack,
	output logic                   o_pause_cpu,      // CPU must hold while high
	bus_master_if.dma              bus
);

	// Sprite states
	// Bit 0 pauses the CPU, bit 1 owns the bus
	localparam logic [1:0] SPR_IDLE = 2'b00;
	localparam logic [1:0] SPR_WAIT = 2'b01; // Paused, waiting for alignment
	localparam logic [1:0] SPR_XFER = 2'b11; // Moving bytes

	logic                   dmc_state;   // DMC fetch armed
	logic [1:0]             spr_state;
	nes_bus_pkg::bus_addr_u spr_addr;    // Source page:offset
	nes_bus_pkg::byte_t     spr_data;    // Byte read on the even cycle
	logic [8:0]             next_offset; // Offset plus carry out
	logic                   spr_active;
	logic                   dmc_fetch;

	assign next_offset = {1'b0, spr_addr.paged.offset} + 9'd1;
	assign spr_active  = spr_state[1];
	assign dmc_fetch   = dmc_state && !i_odd_cycle; // DMC owns this even cycle

	// DMC fetch state
	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= 1'b0;
		end else if (i_cpu_ce) begin
			if (!dmc_state && i_dmc_req && i_cpu_read && !i_odd_cycle) begin
				dmc_state <= 1'b1; // Arm, fetch happens next even cycle
			end else if (dmc_state && !i_odd_cycle) begin
				dmc_state <= 1'b0; // Fetch done
			end
		end
	end

	// Sprite FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
		end else if (i_cpu_ce) begin
			if (spr_active && i_odd_cycle && next_offset[8]) begin
				spr_state <= SPR_IDLE; // Last write to 2004 done
			end else if (spr_active && !i_odd_cycle && dmc_state) begin
				spr_state <= SPR_WAIT; // DMC stole the read, redo the pair
			end else if (spr_state == SPR_WAIT && i_cpu_read && i_odd_cycle) begin
				spr_state <= SPR_XFER; // Next cycle is even
			end else if (i_sprite_trigger) begin
				spr_state <= SPR_WAIT;
			end
		end
	end

	// Source address and data latch
	always_ff @(posedge clk) begin
		if (i_cpu_ce) begin
			if (i_sprite_trigger) begin
				spr_addr.paged.page   <= i_cpu_dout;
				spr_addr.paged.offset <= 8'h00;
			end else if (spr_active && i_odd_cycle) begin
				spr_addr.paged.offset <= next_offset[7:0]; // Step after each write
			end

			if (spr_active) begin
				spr_data <= i_bus_din; // Only the even cycle value gets written
			end
		end
	end

	assign o_dmc_ack   = dmc_fetch;
	assign o_pause_cpu = spr_state[0] || i_dmc_req;

	// Bus request
	assign bus.enable = dmc_fetch || spr_active;
	assign bus.read   = !i_odd_cycle; // Reads on even, writes on odd
	assign bus.wdata  = spr_data;

	// DMC first, then sprite source on even cycles, else OAM data port
	always_comb begin
		if (dmc_fetch) begin
			bus.addr = i_dmc_addr;
		end else if (!i_odd_cycle) begin
			bus.addr = spr_addr;
		end else begin
			bus.addr.word = `OAM_DATA_ADDR;
		end
	end

endmodule

// ==== rtl/cpu_clock_divider.sv ====
`timescale 1ns/10ps

`include "nes_bus_consts.svh"

// Master clock dividers
// CPU ticks every 12 clocks, PPU every 4, both free-running
module cpu_clock_divider (
	input  logic clk,
	input  logic reset,
	output logic o_cpu_ce,    // One clock wide, every CPU_DIV clocks
	output logic o_ppu_ce,    // One clock wide, every PPU_DIV clocks
	output logic o_odd_cycle  // APU half cycle, 1 = odd
);

	logic [4:0] cpu_cnt; // Counts 1 to CPU_DIV
	logic [2:0] ppu_cnt; // Counts 1 to PPU_DIV

	// Enables come straight off the counters
	assign o_cpu_ce = (cpu_cnt == `CPU_DIV);
	assign o_ppu_ce = (ppu_cnt == `PPU_DIV);

	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_cnt <= 5'd1; // Start at 1 so first tick is 11 clocks out
			ppu_cnt <= 3'd1;
		end else begin
			// Wrap back to 1 on the tick itself
			if (o_cpu_ce) begin
				cpu_cnt <= 5'd1;
			end else begin
				cpu_cnt <= cpu_cnt + 5'd1;
			end

			if (o_ppu_ce) begin
				ppu_cnt <= 3'd1;
			end else begin
				ppu_cnt <= ppu_cnt + 3'd1;
			end
		end
	end

	// Even/odd APU cycle
	// Odd out of reset, flips once per CPU cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			o_odd_cycle <= 1'b1;
		end else if (o_cpu_ce) begin
			o_odd_cycle <= ~o_odd_cycle;
		end
	end

endmodule

// ==== rtl/bus_master_if.sv ====
`timescale 1ns/10ps

// DMA side of the bus master mux
// No handshake, the decoder simply follows enable
interface bus_master_if;

	logic                   enable; // DMA owns the bus this CPU cycle
	nes_bus_pkg::bus_addr_u addr;   // DMA address
	nes_bus_pkg::byte_t     wdata;  // Byte written by the DMA
	logic                   read;   // 1 read, 0 write

	// DMA drives everything
	modport dma (
		output enable,
		output addr,
		output wdata,
		output read
	);

	// Decoder picks between these and the CPU
	modport decoder (
		input enable,
		input addr,
		input wdata,
		input read
	);

endinterface

// ==== rtl/nes_bus_pkg.sv ====
package nes_bus_pkg;

	// One byte on the CPU data bus
	typedef logic [7:0] byte_t;

	// Page and offset view of a bus address
	typedef struct packed {
		logic [7:0] page;   // High byte, fixed for a whole sprite DMA
		logic [7:0] offset; // Low byte, walks 00 to FF
	} bus_page_t;

	// CPU bus address
	// DMA steps through it by page and offset
	// Decoder only ever looks at the full word
	typedef union packed {
		logic [15:0] word;   // Flat 16 bit address
		bus_page_t   paged;  // Same bits split in two bytes
	} bus_addr_u;

endpackage

// ==== include/nes_bus_consts.svh ====
`ifndef NES_BUS_CONSTS_SVH
`define NES_BUS_CONSTS_SVH

// Master clock dividers
// 12 master clocks make one CPU cycle
`define CPU_DIV 5'd12
// 4 master clocks make one PPU dot
`define PPU_DIV 3'd4

// Single registers on the CPU bus
// OAM data port, target of every sprite DMA write
`define OAM_DATA_ADDR 16'h2004
// Writing a page here starts sprite DMA
`define OAM_DMA_ADDR 16'h4014
// Only readable APU register
`define APU_STATUS_ADDR 16'h4015
// Joypad 1 data, writes go to the shared strobe latch
`define JOY1_ADDR 16'h4016
// Joypad 2 data
`define JOY2_ADDR 16'h4017

// Device windows, base included and end excluded
// PPU registers and their mirrors
`define PPU_BASE 16'h2000
`define PPU_END 16'h4000
// APU and I/O block
`define APU_BASE 16'h4000
`define APU_END 16'h4018

`endif
